// File: rtl/branch_fu.sv
`default_nettype none

// conditional branch unit, resolves one branch per cycle with one cycle latency
module branch_fu (
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    input  exec_pkg::addr_t     issue_pc,
    input  exec_pkg::inst_t     issue_inst,
    input  exec_pkg::word_t     issue_rs1_value,
    input  exec_pkg::word_t     issue_rs2_value,
    input  logic                issue_pred_taken,
    input  exec_pkg::br_id_t    issue_branch_id,
    output logic                resolve_valid,
    output logic                resolve_taken,
    output logic                resolve_correct,
    output exec_pkg::addr_t     resolve_target,
    output exec_pkg::br_id_t    resolve_id,
    output exec_pkg::br_task_e  br_task
);
    import exec_pkg::*;

    logic [2:0] funct3;
    logic       taken;
    logic       correct;
    addr_t      taken_target;
    addr_t      next_pc;
    addr_t      target;

    assign funct3 = issue_inst[14:12];

    branch_target_adder target_adder_inst (
        .pc           (issue_pc),
        .inst         (issue_inst),
        .taken_target (taken_target),
        .next_pc      (next_pc)
    );

    // branch condition
    always_comb begin
        case (funct3)
            FUNCT3_BEQ:  taken = issue_rs1_value == issue_rs2_value;
            FUNCT3_BNE:  taken = issue_rs1_value != issue_rs2_value;
            FUNCT3_BLT:  taken = $signed(issue_rs1_value) <  $signed(issue_rs2_value);
            FUNCT3_BGE:  taken = $signed(issue_rs1_value) >= $signed(issue_rs2_value);
            FUNCT3_BLTU: taken = issue_rs1_value <  issue_rs2_value; // unsigned
            FUNCT3_BGEU: taken = issue_rs1_value >= issue_rs2_value; // unsigned
            default:     taken = 1'b0; // unused codes fall through
        endcase
    end

    assign target  = taken ? taken_target : next_pc;
    assign correct = issue_pred_taken == taken; // prediction matched outcome

    // result register, zeroed on any idle cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            resolve_valid   <= 1'b0;
            resolve_taken   <= 1'b0;
            resolve_correct <= 1'b0;
            resolve_target  <= '0;
            resolve_id      <= '0;
            br_task         <= BR_NOTHING;
        end else if (issue_valid) begin
            resolve_valid   <= 1'b1;
            resolve_taken   <= taken;
            resolve_correct <= correct;
            resolve_target  <= target;
            resolve_id      <= issue_branch_id; // echo the tag
            br_task         <= correct ? BR_CLEAR : BR_SQUASH;
        end else begin
            resolve_valid   <= 1'b0;
            resolve_taken   <= 1'b0;
            resolve_correct <= 1'b0;
            resolve_target  <= '0;
            resolve_id      <= '0;
            br_task         <= BR_NOTHING;
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_tag_tracker.sv
`default_nettype none

// hands out branch tags and tracks which older tags each one depends on
module branch_tag_tracker (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc_req,
    output logic                alloc_grant,
    output exec_pkg::br_id_t    alloc_id,
    input  exec_pkg::br_task_e  br_task,
    input  exec_pkg::br_id_t    resolve_id,
    output exec_pkg::br_mask_t  busy_mask,
    output exec_pkg::br_mask_t  squash_mask
);
    import exec_pkg::*;

    br_mask_t dep_mask [NUM_BR_TAGS]; // tags that were live when tag t was granted
    br_mask_t clear_mask;             // single bit of a correctly resolved tag
    br_mask_t freed_mask;             // everything released this cycle
    br_mask_t busy_after;             // busy set once the resolution is applied
    logic     any_free;

    // lowest free tag, search from the top so the lowest index wins
    always_comb begin
        alloc_id = '0;
        for (int i = NUM_BR_TAGS - 1; i >= 0; i--) begin
            if (!busy_mask[i]) begin
                alloc_id = br_id_t'(i);
            end
        end
    end

    assign any_free    = ~&busy_mask;
    assign alloc_grant = alloc_req && any_free; // full tracker just ignores the request

    // squash set: resolved tag plus every live tag younger than it
    always_comb begin
        squash_mask = '0;
        if (br_task == BR_SQUASH) begin
            squash_mask[resolve_id] = 1'b1;
            for (int t = 0; t < NUM_BR_TAGS; t++) begin
                if (busy_mask[t] && dep_mask[t][resolve_id]) begin
                    squash_mask[t] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        clear_mask = '0;
        if (br_task == BR_CLEAR) begin
            clear_mask[resolve_id] = 1'b1;
        end
    end

    assign freed_mask = clear_mask | squash_mask;
    assign busy_after = busy_mask & ~freed_mask;

    // resolution first, then the grant on top of it
    always_ff @(posedge clock) begin
        if (reset) begin
            busy_mask <= '0;
            for (int t = 0; t < NUM_BR_TAGS; t++) begin
                dep_mask[t] <= '0;
            end
        end else begin
            busy_mask <= busy_after;
            // drop released tags from every dependency
            for (int t = 0; t < NUM_BR_TAGS; t++) begin
                dep_mask[t] <= dep_mask[t] & ~freed_mask;
            end
            if (alloc_grant) begin
                busy_mask[alloc_id] <= 1'b1;
                dep_mask[alloc_id]  <= busy_after; // older live branches
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_target_adder.sv
`default_nettype none

// B-type target and fall-through address, pure combinational
module branch_target_adder (
    input  exec_pkg::addr_t pc,
    input  exec_pkg::inst_t inst,
    output exec_pkg::addr_t taken_target,
    output exec_pkg::addr_t next_pc
);
    import exec_pkg::*;

    word_t b_imm; // sign-extended 13-bit offset

    // imm[12|10:5] sit in inst[31:25], imm[4:1|11] in inst[11:7]
    assign b_imm = {
        {19{inst[31]}}, // sign extension
        inst[31],       // imm[12]
        inst[7],        // imm[11]
        inst[30:25],    // imm[10:5]
        inst[11:8],     // imm[4:1]
        1'b0            // offsets are always even
    };

    assign taken_target = pc + b_imm;
    assign next_pc      = pc + 32'd4; // no compressed instructions here

endmodule

`default_nettype wire

// File: rtl/exec_branch_top.sv
`default_nettype none

// branch resolution stage: branch unit feeding the tag tracker
module exec_branch_top (
    input  logic                clock,
    input  logic                reset,

    // tag allocation from dispatch
    input  logic                alloc_req,
    output logic                alloc_grant,
    output exec_pkg::br_id_t    alloc_id,

    // issued branch, one per cycle at most
    input  logic                issue_valid,
    input  exec_pkg::addr_t     issue_pc,
    input  exec_pkg::inst_t     issue_inst,
    input  exec_pkg::word_t     issue_rs1_value,
    input  exec_pkg::word_t     issue_rs2_value,
    input  logic                issue_pred_taken,
    input  exec_pkg::br_id_t    issue_branch_id,

    // resolution, one cycle after issue
    output logic                resolve_valid,
    output logic                resolve_taken,
    output logic                resolve_correct,
    output exec_pkg::addr_t     resolve_target,
    output exec_pkg::br_id_t    resolve_id,
    output exec_pkg::br_task_e  br_task,

    // tag state
    output exec_pkg::br_mask_t  busy_mask,
    output exec_pkg::br_mask_t  squash_mask
);

    branch_fu branch_fu_inst (
        .clock            (clock),
        .reset            (reset),
        .issue_valid      (issue_valid),
        .issue_pc         (issue_pc),
        .issue_inst       (issue_inst),
        .issue_rs1_value  (issue_rs1_value),
        .issue_rs2_value  (issue_rs2_value),
        .issue_pred_taken (issue_pred_taken),
        .issue_branch_id  (issue_branch_id),
        .resolve_valid    (resolve_valid),
        .resolve_taken    (resolve_taken),
        .resolve_correct  (resolve_correct),
        .resolve_target   (resolve_target),
        .resolve_id       (resolve_id),
        .br_task          (br_task)
    );

    // tracker only looks at br_task and the tag it names
    branch_tag_tracker branch_tag_tracker_inst (
        .clock       (clock),
        .reset       (reset),
        .alloc_req   (alloc_req),
        .alloc_grant (alloc_grant),
        .alloc_id    (alloc_id),
        .br_task     (br_task),
        .resolve_id  (resolve_id),
        .busy_mask   (busy_mask),
        .squash_mask (squash_mask)
    );

endmodule

`default_nettype wire

// File: rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int INST_BITS = 32;

    // in-flight branches
    localparam int NUM_BR_TAGS = 4;
    localparam int BR_ID_BITS  = $clog2(NUM_BR_TAGS); // 2 bits for 4 tags

    typedef logic [XLEN-1:0]      word_t;    // register operand or computed target
    typedef logic [XLEN-1:0]      addr_t;    // instruction address
    typedef logic [INST_BITS-1:0] inst_t;    // raw instruction word

    typedef logic [BR_ID_BITS-1:0]  br_id_t;   // branch tag
    typedef logic [NUM_BR_TAGS-1:0] br_mask_t; // one bit per tag

    // action broadcast by the branch unit one cycle after issue
    typedef enum logic [1:0] {
        BR_NOTHING = 2'd0, // idle cycle
        BR_CLEAR   = 2'd1, // prediction held, free the tag
        BR_SQUASH  = 2'd2  // mispredict, free tag and younger ones
    } br_task_e;

    // funct3 of B-type instructions, inst[14:12]
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    // 3'b010 and 3'b011 are unused, branch never taken
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb_top

output=$(./obj_dir/sim_tb_top)
echo "$output"

echo "$output" | grep -q -- '>>> PASS'

// File: tb.f
rtl/exec_pkg.sv
rtl/branch_target_adder.sv
rtl/branch_fu.sv
rtl/branch_tag_tracker.sv
rtl/exec_branch_top.sv
verif/branch_properties.sv
verif/tb_top.sv

// File: verif/branch_properties.sv
`default_nettype none

// checks on the branch unit outputs, bound into exec_branch_top
module branch_properties (
    input logic                clock,
    input logic                reset,
    input logic                issue_valid,
    input exec_pkg::addr_t     issue_pc,
    input exec_pkg::inst_t     issue_inst,
    input exec_pkg::word_t     issue_rs1_value,
    input exec_pkg::word_t     issue_rs2_value,
    input logic                issue_pred_taken,
    input exec_pkg::br_id_t    issue_branch_id,
    input logic                resolve_valid,
    input logic                resolve_taken,
    input logic                resolve_correct,
    input exec_pkg::addr_t     resolve_target,
    input exec_pkg::br_id_t    resolve_id,
    input exec_pkg::br_task_e  br_task
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    int error_count = 0; // watched by the testbench

    // branch condition straight from the RV32I rules
    function automatic logic ref_taken(inst_t inst, word_t a, word_t b);
        case (inst[14:12])
            FUNCT3_BEQ:  return a == b;
            FUNCT3_BNE:  return a != b;
            FUNCT3_BLT:  return (a[31] != b[31]) ? a[31] : (a < b); // sign bits first
            FUNCT3_BGE:  return (a[31] != b[31]) ? b[31] : (a >= b);
            FUNCT3_BLTU: return a < b;
            FUNCT3_BGEU: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    // prediction against the reference outcome
    function automatic logic ref_correct(logic pred, inst_t inst, word_t a, word_t b);
        return pred == ref_taken(inst, a, b);
    endfunction

    function automatic addr_t ref_target(addr_t pc, inst_t inst, word_t a, word_t b);
        logic [12:0] offset;
        offset = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (ref_taken(inst, a, b)) begin
            return pc + {{19{offset[12]}}, offset};
        end
        return pc + 32'd4;
    endfunction

    // valid follows issue by exactly one cycle
    assert property (@(posedge clock) disable iff (reset)
        resolve_valid == $past(issue_valid))
    else begin
        $error("ERROR t=%0t resolve_valid expected %0b got %0b", $time,
            $past(issue_valid), $sampled(resolve_valid));
        error_count++;
    end

    // quiet outputs after reset or an idle cycle
    assert property (@(posedge clock)
        ($past(reset) || !$past(issue_valid)) |-> (!resolve_valid && br_task == BR_NOTHING))
    else begin
        $error("ERROR t=%0t br_task expected %0d got %0d", $time,
            BR_NOTHING, $sampled(br_task));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        $past(issue_valid) |-> resolve_taken ==
            ref_taken($past(issue_inst), $past(issue_rs1_value), $past(issue_rs2_value)))
    else begin
        $error("ERROR t=%0t resolve_taken expected %0b got %0b", $time,
            ref_taken($past(issue_inst), $past(issue_rs1_value), $past(issue_rs2_value)),
            $sampled(resolve_taken));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        $past(issue_valid) |-> resolve_target == ref_target($past(issue_pc),
            $past(issue_inst), $past(issue_rs1_value), $past(issue_rs2_value)))
    else begin
        $error("ERROR t=%0t resolve_target expected %0h got %0h", $time,
            ref_target($past(issue_pc), $past(issue_inst), $past(issue_rs1_value),
                $past(issue_rs2_value)),
            $sampled(resolve_target));
        error_count++;
    end

    // prediction check
    assert property (@(posedge clock) disable iff (reset)
        $past(issue_valid) |-> resolve_correct == ref_correct($past(issue_pred_taken),
            $past(issue_inst), $past(issue_rs1_value), $past(issue_rs2_value)))
    else begin
        $error("ERROR t=%0t resolve_correct expected %0b got %0b", $time,
            ref_correct($past(issue_pred_taken), $past(issue_inst),
                $past(issue_rs1_value), $past(issue_rs2_value)),
            $sampled(resolve_correct));
        error_count++;
    end

    // matching broadcast, clear on a hit and squash on a miss
    assert property (@(posedge clock) disable iff (reset)
        $past(issue_valid) |-> br_task == (ref_correct($past(issue_pred_taken),
            $past(issue_inst), $past(issue_rs1_value), $past(issue_rs2_value))
            ? BR_CLEAR : BR_SQUASH))
    else begin
        $error("ERROR t=%0t br_task expected %0d got %0d", $time,
            ref_correct($past(issue_pred_taken), $past(issue_inst),
                $past(issue_rs1_value), $past(issue_rs2_value)) ? BR_CLEAR : BR_SQUASH,
            $sampled(br_task));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        $past(issue_valid) |-> resolve_id == $past(issue_branch_id))
    else begin
        $error("ERROR t=%0t resolve_id expected %0d got %0d", $time,
            $past(issue_branch_id), $sampled(resolve_id));
        error_count++;
    end

endmodule

bind exec_branch_top branch_properties branch_properties_inst (.*);

`default_nettype wire

// File: verif/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int RANDOM_CYCLES  = 300;
    localparam int TIMEOUT_CYCLES = 5000; // well above sweep, random and tag phases
    localparam logic [31:0] SEED  = 32'h2889;

    logic       clock;
    logic       reset;
    logic       alloc_req;
    logic       alloc_grant;
    br_id_t     alloc_id;
    logic       issue_valid;
    addr_t      issue_pc;
    inst_t      issue_inst;
    word_t      issue_rs1_value;
    word_t      issue_rs2_value;
    logic       issue_pred_taken;
    br_id_t     issue_branch_id;
    logic       resolve_valid;
    logic       resolve_taken;
    logic       resolve_correct;
    addr_t      resolve_target;
    br_id_t     resolve_id;
    br_task_e   br_task;
    br_mask_t   busy_mask;
    br_mask_t   squash_mask;

    br_mask_t   model_busy;               // shadow of the tracker
    br_mask_t   model_dep [NUM_BR_TAGS];
    int         cycle_count = 0;

    exec_branch_top exec_branch_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] actv);
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, expv, actv);
        $display(">>> FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    function automatic br_id_t lowest_free(br_mask_t busy);
        for (int i = 0; i < NUM_BR_TAGS; i++) begin
            if (!busy[i]) return br_id_t'(i);
        end
        return '0;
    endfunction

    // B-type encoding, opcode 1100011
    function automatic inst_t encode_branch(logic [2:0] f, logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic issue_branch(logic [2:0] f, word_t a, word_t b, logic pred,
                                br_id_t id, logic [12:0] imm, logic req);
        @(posedge clock);
        issue_valid      <= 1'b1;
        issue_pc         <= {$urandom()} & 32'hffff_fffc;
        issue_inst       <= encode_branch(f, imm);
        issue_rs1_value  <= a;
        issue_rs2_value  <= b;
        issue_pred_taken <= pred;
        issue_branch_id  <= id;
        alloc_req        <= req;
    endtask

    task automatic idle_cycle(logic req);
        @(posedge clock);
        issue_valid <= 1'b0;
        alloc_req   <= req;
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    // every funct3 against equal, boundary and sign-crossing pairs
    task automatic run_condition_sweep();
        word_t pair_a [7] = '{32'h5, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff,
                              32'h0, 32'h1, 32'h0};
        word_t pair_b [7] = '{32'h5, 32'h8000_0000, 32'h7fff_ffff, 32'h0,
                              32'hffff_ffff, 32'h2, 32'h0};
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 7; p++) begin
                issue_branch(3'(f), pair_a[p], pair_b[p], 1'($urandom()),
                    2'($urandom()), 13'($urandom()), 1'b0);
            end
            idle_cycle(1'b0);
        end
    endtask

    task automatic run_random_branches(int count);
        word_t a;
        word_t b;
        word_t corners [4] = '{32'h0, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000};
        for (int n = 0; n < count; n++) begin
            a = $urandom();
            b = $urandom();
            case ($urandom() % 4)
                0: b = a;                                  // equal
                1: b = corners[$urandom() % 4];            // boundary
                2: b = a ^ 32'h8000_0000;                  // sign crossing
                default: ;
            endcase
            if ($urandom() % 4 != 0) begin
                issue_branch(3'($urandom()), a, b, 1'($urandom()), 2'($urandom()),
                    13'($urandom()), 1'($urandom()));
            end else begin
                idle_cycle(1'($urandom()));
            end
        end
        idle_cycle(1'b0);
    endtask

    task automatic run_tag_sequences();
        repeat (4) idle_cycle(1'b1);                       // grants 0..3
        idle_cycle(1'b1);                                  // full, no grant
        issue_branch(FUNCT3_BEQ, 32'd5, 32'd5, 1'b1, 2'd1, 13'h10, 1'b0); // clear tag 1
        repeat (2) idle_cycle(1'b0);
        idle_cycle(1'b1);                                  // tag 1 comes back
        issue_branch(FUNCT3_BEQ, 32'd5, 32'd5, 1'b0, 2'd0, 13'h10, 1'b0); // squash all
        repeat (2) idle_cycle(1'b0);
        repeat (4) idle_cycle(1'b1);
        issue_branch(FUNCT3_BNE, 32'd5, 32'd5, 1'b1, 2'd1, 13'h1f00, 1'b0); // squash 1..3
        repeat (2) idle_cycle(1'b0);
        issue_branch(FUNCT3_BEQ, 32'd7, 32'd7, 1'b1, 2'd0, 13'h8, 1'b0); // clear tag 0
        repeat (3) idle_cycle(1'b0);
    endtask

    // shadow tag model, compared before each update
    always @(posedge clock) begin : tag_model
        br_mask_t freed;
        br_mask_t after;
        logic     exp_grant;
        br_id_t   exp_id;
        if (reset) begin
            model_busy = '0;
            for (int t = 0; t < NUM_BR_TAGS; t++) model_dep[t] = '0;
        end else begin
            exp_grant = alloc_req && (model_busy != '1);
            exp_id    = lowest_free(model_busy);
            freed     = '0;
            if (br_task == BR_CLEAR) begin
                freed[resolve_id] = 1'b1;
            end else if (br_task == BR_SQUASH) begin
                freed[resolve_id] = 1'b1;
                for (int t = 0; t < NUM_BR_TAGS; t++) begin
                    if (model_busy[t] && model_dep[t][resolve_id]) freed[t] = 1'b1;
                end
            end
            assert (busy_mask == model_busy)
            else report_mismatch("busy_mask", 32'(model_busy), 32'(busy_mask));
            assert (alloc_grant == exp_grant)
            else report_mismatch("alloc_grant", 32'(exp_grant), 32'(alloc_grant));
            assert (!exp_grant || alloc_id == exp_id)
            else report_mismatch("alloc_id", 32'(exp_id), 32'(alloc_id));
            assert (squash_mask == ((br_task == BR_SQUASH) ? freed : '0))
            else report_mismatch("squash_mask", 32'(freed), 32'(squash_mask));
            after = model_busy & ~freed;
            for (int t = 0; t < NUM_BR_TAGS; t++) model_dep[t] = model_dep[t] & ~freed;
            model_busy = after;
            if (exp_grant) begin
                model_busy[exp_id] = 1'b1;
                model_dep[exp_id]  = after;       // older live tags
            end
        end
    end

    // concurrent assertion failures from the bound checker
    always @(negedge clock) begin
        if (exec_branch_top_inst.branch_properties_inst.error_count != 0) begin
            $display(">>> FAIL");
            $fatal(1, "a branch resolution assertion failed");
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(SEED));
        reset            = 1'b1;
        alloc_req        = 1'b0;
        issue_valid      = 1'b0;
        issue_pc         = '0;
        issue_inst       = '0;
        issue_rs1_value  = '0;
        issue_rs2_value  = '0;
        issue_pred_taken = 1'b0;
        issue_branch_id  = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        run_condition_sweep();
        run_random_branches(RANDOM_CYCLES);
        apply_reset();                       // empty tracker for the ordered cases
        run_tag_sequences();
        repeat (2) @(negedge clock);
        if (exec_branch_top_inst.branch_properties_inst.error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

`default_nettype wire
